/* video_pkg.sv */
// video package with timing constants, register addresses and shared packed structs
`default_nettype none

package video_pkg;

	// --------------------------------------------------
	// beam timing, fixed by the console
	// --------------------------------------------------
	localparam int LINE_CYCLES   = 456;
	localparam int FRAME_LINES   = 154;
	localparam int VISIBLE_LINES = 144;
	localparam int OAM_CYCLES    = 80;
	localparam int DRAW_CYCLES   = 172;
	localparam int SCREEN_WIDTH  = 160;

	// oam dma moves one byte every four cycles
	localparam int DMA_BYTES = 160;
	localparam int DMA_SLOT  = 4;

	// --------------------------------------------------
	// register offsets inside the ff00 page
	// --------------------------------------------------
	localparam logic [7:0] REG_LCDC = 8'h40;
	localparam logic [7:0] REG_STAT = 8'h41;
	localparam logic [7:0] REG_SCY  = 8'h42;
	localparam logic [7:0] REG_SCX  = 8'h43;
	localparam logic [7:0] REG_LY   = 8'h44;
	localparam logic [7:0] REG_LYC  = 8'h45;
	localparam logic [7:0] REG_DMA  = 8'h46;
	localparam logic [7:0] REG_BGP  = 8'h47;

	// cpu side of the register and oam port
	typedef struct packed {
		logic       sel_oam;
		logic       sel_reg;
		logic [7:0] addr;
		logic       wr;
		logic [7:0] di;
	} cpu_bus_t;

	// lcdc bit layout, msb first
	// window and sprite fields are stored for readback only
	typedef struct packed {
		logic on;
		logic win_map_sel;
		logic win_ena;
		logic tile_data_sel;
		logic bg_map_sel;
		logic spr_size;
		logic spr_ena;
		logic bg_ena;
	} lcdc_t;

	// stat interrupt enables, stat bits 6 down to 3
	typedef struct packed {
		logic lyc;
		logic oam;
		logic vblank;
		logic hblank;
	} stat_en_t;

	typedef struct packed {
		lcdc_t      lcdc;
		stat_en_t   stat_en;
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] lyc;
		logic [7:0] bgp;
	} video_regs_t;

	// beam position and the decoded line events
	typedef struct packed {
		logic [8:0] h_cnt;
		logic [7:0] v_cnt;
		logic [1:0] mode;
		logic       draw;
		logic       line_start;
		logic       lyc_match;
	} beam_t;

	// background pixel before the palette
	typedef struct packed {
		logic       valid;
		logic [1:0] idx;
	} bg_pixel_t;

endpackage

`default_nettype wire

/* video_reg_decode.sv */
// video_reg_decode module with cpu register file, write decode and readback mux
`timescale 1ns/10ps
`default_nettype none

module video_reg_decode import video_pkg::*; (
	input  wire logic        clk_reg,
	input  wire logic        reset,
	input  wire cpu_bus_t    cpu,
	input  wire beam_t       beam,
	output video_regs_t      regs,
	output logic             dma_start,
	output logic [7:0]       reg_do
);

	// last value written to the dma register, read back only
	logic [7:0] dma_reg;
	logic       reg_wr;

	assign reg_wr = cpu.sel_reg && cpu.wr;

	// --------------------------------------------------
	// register writes
	// --------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// display comes up off
			regs.lcdc    <= '0;
			regs.stat_en <= '0;
			regs.scy     <= 8'h00;
			regs.scx     <= 8'h00;
			regs.lyc     <= 8'h00;
			// boot palette
			regs.bgp     <= 8'hfc;
		end else if (reg_wr) begin
			case (cpu.addr)
				REG_LCDC: regs.lcdc    <= cpu.di;
				// only the enable bits are writable
				REG_STAT: regs.stat_en <= cpu.di[6:3];
				REG_SCY:  regs.scy     <= cpu.di;
				REG_SCX:  regs.scx     <= cpu.di;
				REG_LYC:  regs.lyc     <= cpu.di;
				REG_BGP:  regs.bgp     <= cpu.di;
				default:  regs.lcdc    <= regs.lcdc;
			endcase
		end
	end

	always_ff @(posedge clk_reg) begin
		if (reg_wr && (cpu.addr == REG_DMA))
			dma_reg <= cpu.di;
	end

	// start strobe in the write cycle itself
	// the dma engine goes busy on the following edge
	assign dma_start = reg_wr && (cpu.addr == REG_DMA);

	// --------------------------------------------------
	// readback
	// --------------------------------------------------
	always_comb begin
		case (cpu.addr)
			REG_LCDC: reg_do = regs.lcdc;
			// bit 7 always reads as one
			REG_STAT: reg_do = {1'b1, regs.stat_en, beam.lyc_match, beam.mode};
			REG_SCY:  reg_do = regs.scy;
			REG_SCX:  reg_do = regs.scx;
			// ly is the line counter itself
			REG_LY:   reg_do = beam.v_cnt;
			REG_LYC:  reg_do = regs.lyc;
			REG_DMA:  reg_do = dma_reg;
			REG_BGP:  reg_do = regs.bgp;
			// open bus
			default:  reg_do = 8'hff;
		endcase
	end

endmodule

`default_nettype wire

/* video_beam_timing.sv */
// video_beam_timing module with line/frame counters, stat mode, scroll latches and irq
`timescale 1ns/10ps
`default_nettype none

module video_beam_timing import video_pkg::*; (
	input  wire logic        clk_reg,
	input  wire logic        reset,
	input  wire video_regs_t regs,
	output beam_t            beam,
	output logic [7:0]       scx_line,
	output logic [7:0]       scy_line,
	output logic             irq
);

	logic [8:0] h_cnt;
	logic [7:0] v_cnt;
	logic       vblank;
	logic       lyc_match;
	logic       ev_lyc;
	logic       ev_oam;
	logic       ev_vblank;
	logic       ev_hblank;

	// --------------------------------------------------
	// counters, held at zero while the lcd is off
	// --------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset || !regs.lcdc.on) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == LINE_CYCLES - 1) begin
			h_cnt <= '0;
			if (v_cnt == FRAME_LINES - 1)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// scroll is frozen two cycles before drawing starts
	always_ff @(posedge clk_reg) begin
		if (regs.lcdc.on && (h_cnt == OAM_CYCLES - 2)) begin
			scx_line <= regs.scx;
			scy_line <= regs.scy;
		end
	end

	assign vblank    = (v_cnt >= VISIBLE_LINES);
	assign lyc_match = (v_cnt == regs.lyc);

	// --------------------------------------------------
	// mode decode and line events
	// --------------------------------------------------
	always_comb begin
		beam.h_cnt = h_cnt;
		beam.v_cnt = v_cnt;
		// 0 hblank, 1 vblank, 2 oam scan, 3 drawing
		if (!regs.lcdc.on)
			beam.mode = 2'd0;
		else if (vblank)
			beam.mode = 2'd1;
		else if (h_cnt < OAM_CYCLES)
			beam.mode = 2'd2;
		else if (h_cnt < OAM_CYCLES + DRAW_CYCLES)
			beam.mode = 2'd3;
		else
			beam.mode = 2'd0;
		beam.draw       = (beam.mode == 2'd3);
		beam.line_start = regs.lcdc.on && !vblank && (h_cnt == OAM_CYCLES - 2);
		beam.lyc_match  = lyc_match;
	end

	// --------------------------------------------------
	// stat interrupt sources
	// --------------------------------------------------
	// oam and hblank fire on visible lines only
	assign ev_lyc    = regs.stat_en.lyc && (h_cnt == 9'd1) && lyc_match;
	assign ev_oam    = regs.stat_en.oam && (h_cnt == 9'd0) && !vblank;
	assign ev_vblank = regs.stat_en.vblank && (h_cnt == LINE_CYCLES - 1) &&
		(v_cnt == VISIBLE_LINES - 1);
	assign ev_hblank = regs.stat_en.hblank && (h_cnt == OAM_CYCLES + DRAW_CYCLES) && !vblank;

	// single cycle pulse one clock after the event
	always_ff @(posedge clk_reg) begin
		if (reset)
			irq <= 1'b0;
		else
			irq <= regs.lcdc.on && (ev_lyc || ev_oam || ev_vblank || ev_hblank);
	end

endmodule

`default_nettype wire

/* video_bg_fetch.sv */
// video_bg_fetch module with vram fetch sequencer, tile addressing and pixel shifters
`timescale 1ns/10ps
`default_nettype none

module video_bg_fetch import video_pkg::*; (
	input  wire logic        clk_reg,
	input  wire logic        reset,
	input  wire video_regs_t regs,
	input  wire beam_t       beam,
	input  wire logic [7:0]  scx_line,
	input  wire logic [7:0]  scy_line,
	output logic             vram_rd,
	output logic [12:0]      vram_addr,
	input  wire logic [7:0]  vram_data,
	output bg_pixel_t        pixel
);

	// one extra tile covers the fine scroll discard
	localparam int FETCH_TILES = SCREEN_WIDTH / 8 + 1;

	logic [2:0] phase;
	logic       fetch_en;
	logic       load;
	logic [4:0] tile_cnt;
	logic [7:0] bg_line;
	logic [4:0] map_col;
	logic       tile_a12;
	logic [7:0] tile_num;
	logic [7:0] data_lo;
	logic [7:0] data_hi;
	logic [7:0] shift_lo;
	logic [7:0] shift_hi;
	logic [3:0] sh_cnt;
	logic [2:0] skip_cnt;
	logic [7:0] out_cnt;
	logic       take;
	logic       emit;
	logic       pix_valid;
	logic [1:0] pix_idx;

	// drawing starts at h_cnt 80 so slots line up with the low counter bits
	assign phase    = beam.h_cnt[2:0];
	assign fetch_en = beam.draw && (tile_cnt < FETCH_TILES);
	assign load     = fetch_en && (phase == 3'd7);

	// --------------------------------------------------
	// vram addressing
	// --------------------------------------------------
	assign bg_line = beam.v_cnt + scy_line;
	// column wraps inside the 32 tile map row
	assign map_col = scx_line[7:3] + tile_cnt;
	// signed mode puts tiles 0..127 at 1000h and 128..255 at 0800h
	assign tile_a12 = !regs.lcdc.tile_data_sel && !tile_num[7];

	// slot phases 0-1 map, 2-3 low plane, 4-5 high plane, 6-7 idle
	assign vram_rd = fetch_en && (phase[2:1] != 2'b11);

	always_comb begin
		case (phase[2:1])
			2'b00:   vram_addr = {2'b11, regs.lcdc.bg_map_sel, bg_line[7:3], map_col};
			2'b01:   vram_addr = {tile_a12, tile_num, bg_line[2:0], 1'b0};
			default: vram_addr = {tile_a12, tile_num, bg_line[2:0], 1'b1};
		endcase
	end

	// data is valid on the second cycle of each access
	always_ff @(posedge clk_reg) begin
		if (fetch_en && (phase == 3'd1))
			tile_num <= vram_data;
		if (fetch_en && (phase == 3'd3))
			data_lo <= vram_data;
		if (fetch_en && (phase == 3'd5))
			data_hi <= vram_data;
	end

	// --------------------------------------------------
	// pixel shifters with the msb leaving first
	// --------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (load) begin
			shift_lo <= data_lo;
			shift_hi <= data_hi;
		end else begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end
		pix_idx <= {shift_hi[7], shift_lo[7]};
	end

	// a bit is consumed every cycle while the shifter holds data
	assign take = (sh_cnt != 4'd0);
	assign emit = take && (skip_cnt == 3'd0) && (out_cnt < SCREEN_WIDTH);

	always_ff @(posedge clk_reg) begin
		if (reset || !regs.lcdc.on) begin
			tile_cnt  <= '0;
			sh_cnt    <= '0;
			skip_cnt  <= '0;
			out_cnt   <= '0;
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= emit;
			if (beam.line_start) begin
				tile_cnt <= '0;
				out_cnt  <= '0;
			end else begin
				if (load)
					tile_cnt <= tile_cnt + 5'd1;
				// first tile of a line drops scx mod 8 leading pixels
				if (load && (tile_cnt == 5'd0))
					skip_cnt <= scx_line[2:0];
				else if (take && (skip_cnt != 3'd0))
					skip_cnt <= skip_cnt - 3'd1;
				if (emit)
					out_cnt <= out_cnt + 8'd1;
			end
			// reload replaces the last bit of the previous tile
			if (load)
				sh_cnt <= 4'd8;
			else if (take)
				sh_cnt <= sh_cnt - 4'd1;
		end
	end

	assign pixel = '{valid: pix_valid, idx: pix_idx};

endmodule

`default_nettype wire

/* video_shade_out.sv */
// video_shade_out module with bgp palette lookup and registered lcd output
`timescale 1ns/10ps
`default_nettype none

module video_shade_out import video_pkg::*; (
	input  wire logic        clk_reg,
	input  wire logic        reset,
	input  wire video_regs_t regs,
	input  wire bg_pixel_t   pixel,
	output logic             lcd_clkena,
	output logic [1:0]       lcd_data
);

	logic [1:0] shade;

	// two bits of bgp per colour index
	// background disabled shows white
	always_comb begin
		if (regs.lcdc.bg_ena)
			shade = regs.bgp[{pixel.idx, 1'b0} +: 2];
		else
			shade = 2'd0;
	end

	always_ff @(posedge clk_reg) begin
		if (reset)
			lcd_clkena <= 1'b0;
		else
			lcd_clkena <= pixel.valid;
	end

	always_ff @(posedge clk_reg) begin
		lcd_data <= shade;
	end

endmodule

`default_nettype wire

/* video_oam_dma.sv */
// video_oam_dma module with oam store, cpu and dma write ports and dma sequencer
`timescale 1ns/10ps
`default_nettype none

module video_oam_dma import video_pkg::*; (
	input  wire logic       clk_reg,
	input  wire logic       reset,
	input  wire cpu_bus_t   cpu,
	input  wire logic       dma_start,
	input  wire logic [7:0] dma_page,
	output logic            dma_rd,
	output logic [15:0]     dma_addr,
	input  wire logic [7:0] dma_data,
	output logic [7:0]      oam_do
);

	logic [7:0] oam_mem [DMA_BYTES];
	logic       dma_active;
	logic [9:0] dma_cnt;
	logic [7:0] page_q;

	// --------------------------------------------------
	// dma sequencer, 160 slots of 4 cycles
	// --------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			dma_active <= 1'b0;
			dma_cnt    <= '0;
		end else if (dma_start) begin
			// a second write restarts from byte 0
			dma_active <= 1'b1;
			dma_cnt    <= '0;
		end else if (dma_active) begin
			if (dma_cnt == DMA_BYTES * DMA_SLOT - 1)
				dma_active <= 1'b0;
			else
				dma_cnt <= dma_cnt + 10'd1;
		end
	end

	always_ff @(posedge clk_reg) begin
		if (dma_start)
			page_q <= dma_page;
	end

	assign dma_rd   = dma_active;
	assign dma_addr = {page_q, dma_cnt[9:2]};

	// dma owns the store while busy
	// source byte is taken in the third cycle of its slot
	always_ff @(posedge clk_reg) begin
		if (dma_active) begin
			if (dma_cnt[1:0] == 2'd2)
				oam_mem[dma_cnt[9:2]] <= dma_data;
		end else if (cpu.sel_oam && cpu.wr && (cpu.addr < DMA_BYTES)) begin
			oam_mem[cpu.addr] <= cpu.di;
		end
	end

	// above the 160 byte table reads as open bus
	assign oam_do = (cpu.addr < DMA_BYTES) ? oam_mem[cpu.addr] : 8'hff;

endmodule

`default_nettype wire

/* video_top.sv */
// video_top module wiring register decode, beam timing, fetch, shade output and oam dma
`timescale 1ns/10ps
`default_nettype none

module video_top import video_pkg::*; (
	input  wire logic        clk_reg,
	input  wire logic        reset,
	input  wire cpu_bus_t    cpu,
	output logic [7:0]       cpu_do,
	output logic             lcd_on,
	output logic             lcd_clkena,
	output logic [1:0]       lcd_data,
	output logic             irq,
	output logic [1:0]       mode,
	output logic             vram_rd,
	output logic [12:0]      vram_addr,
	input  wire logic [7:0]  vram_data,
	output logic             dma_rd,
	output logic [15:0]      dma_addr,
	input  wire logic [7:0]  dma_data
);

	video_regs_t regs;
	beam_t       beam;
	bg_pixel_t   pixel;
	logic        dma_start;
	logic [7:0]  reg_do;
	logic [7:0]  oam_do;
	logic [7:0]  scx_line;
	logic [7:0]  scy_line;

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	video_reg_decode u_reg_decode (
		.clk_reg   (clk_reg),
		.reset     (reset),
		.cpu       (cpu),
		.beam      (beam),
		.regs      (regs),
		.dma_start (dma_start),
		.reg_do    (reg_do)
	);

	// --------------------------------------------------
	// beam and background fetch
	// --------------------------------------------------
	video_beam_timing u_beam_timing (
		.clk_reg  (clk_reg),
		.reset    (reset),
		.regs     (regs),
		.beam     (beam),
		.scx_line (scx_line),
		.scy_line (scy_line),
		.irq      (irq)
	);

	video_bg_fetch u_bg_fetch (
		.clk_reg   (clk_reg),
		.reset     (reset),
		.regs      (regs),
		.beam      (beam),
		.scx_line  (scx_line),
		.scy_line  (scy_line),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.pixel     (pixel)
	);

	// palette and lcd register
	video_shade_out u_shade_out (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.regs       (regs),
		.pixel      (pixel),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data)
	);

	// dma page is the byte written to the dma register
	video_oam_dma u_oam_dma (
		.clk_reg   (clk_reg),
		.reset     (reset),
		.cpu       (cpu),
		.dma_start (dma_start),
		.dma_page  (cpu.di),
		.dma_rd    (dma_rd),
		.dma_addr  (dma_addr),
		.dma_data  (dma_data),
		.oam_do    (oam_do)
	);

	assign cpu_do = cpu.sel_oam ? oam_do : reg_do;
	assign lcd_on = regs.lcdc.on;
	assign mode   = beam.mode;

endmodule

`default_nettype wire

/* tb_video_model.svh */
// testbench lfsr, background fetch and palette reference, dma source data
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

// fibonacci lfsr with taps 16 14 13 11
logic [15:0] lfsr_state;

// one lfsr step per bit, newest bit lands in bit 0
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

// colour index of screen pixel x on line ly, straight from the vram image
function automatic logic [1:0] bg_index(input int ly, input int x, input logic [7:0] scx,
	input logic [7:0] scy, input logic map_sel, input logic data_sel);
	logic [7:0] bg_x;
	logic [7:0] bg_y;
	logic [7:0] tile;
	logic [7:0] lo;
	logic [7:0] hi;
	int         map_addr;
	int         data_addr;
	int         bit_pos;
	// background wraps at 256 in both directions
	bg_y = ly[7:0] + scy;
	bg_x = x[7:0] + scx;
	map_addr = (map_sel ? 'h1c00 : 'h1800) + 32 * bg_y[7:3] + bg_x[7:3];
	tile = vram_mem[map_addr];
	// signed tile numbers are centred on 1000h
	if (data_sel)
		data_addr = 16 * tile;
	else
		data_addr = 4096 + 16 * $signed(tile);
	data_addr = data_addr + 2 * bg_y[2:0];
	lo = vram_mem[data_addr];
	hi = vram_mem[data_addr + 1];
	// leftmost pixel is the msb
	bit_pos = 7 - bg_x[2:0];
	return {hi[bit_pos], lo[bit_pos]};
endfunction

// bgp holds two bits per colour index
function automatic logic [1:0] palette_shade(input logic [7:0] bgp, input logic [1:0] idx);
	return bgp[2 * idx +: 2];
endfunction

// dma source byte, every address bit matters
function automatic logic [7:0] dma_byte(input logic [15:0] a);
	return a[15:8] ^ {a[3:0], a[7:4]} ^ 8'h3c;
endfunction

`endif

/* tb_video.sv */
// tb_video testbench top with clock, reset, memory models, stimulus, checks and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_video import video_pkg::*; ();

	localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
	// seven frames of beam tests plus register and dma traffic and some margin
	localparam int TIMEOUT_CYCLES = 7 * FRAME_CYCLES + 4000;

	logic        clk_reg;
	logic        reset;
	cpu_bus_t    cpu;
	logic [7:0]  cpu_do;
	logic        lcd_on;
	logic        lcd_clkena;
	logic [1:0]  lcd_data;
	logic        irq;
	logic [1:0]  mode;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data;
	logic        dma_rd;
	logic [15:0] dma_addr;
	logic [7:0]  dma_data;

	logic [7:0]  vram_mem [8192];
	int          cycle_cnt;
	int          checks;
	int          errors;
	int          test_errors;
	int          tests_run;

	`include "tb_video_model.svh"

	video_top uut (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.cpu        (cpu),
		.cpu_do     (cpu_do),
		.lcd_on     (lcd_on),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data),
		.irq        (irq),
		.mode       (mode),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.dma_rd     (dma_rd),
		.dma_addr   (dma_addr),
		.dma_data   (dma_data)
	);

	initial begin
		clk_reg = 1'b0;
		forever #4 clk_reg = ~clk_reg;
	end

	// --------------------------------------------------
	// memory models and watchdog
	// --------------------------------------------------
	// vram answers one cycle after the address
	always @(posedge clk_reg)
		vram_data <= vram_mem[vram_addr];

	always @(posedge clk_reg)
		dma_data <= dma_byte(dma_addr);

	always @(posedge clk_reg)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// --------------------------------------------------
	// bus tasks and reporting
	// --------------------------------------------------
	task automatic cpu_write(input logic sel_oam, input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk_reg);
		cpu <= {sel_oam, !sel_oam, addr, 1'b1, data};
		@(posedge clk_reg);
		// bus rests on a ly read
		cpu <= {1'b0, 1'b1, REG_LY, 1'b0, 8'h00};
	endtask

	// combinational readback is sampled mid cycle
	task automatic cpu_read(input logic sel_oam, input logic [7:0] addr, output logic [7:0] data);
		@(posedge clk_reg);
		cpu <= {sel_oam, !sel_oam, addr, 1'b0, 8'h00};
		@(negedge clk_reg);
		data = cpu_do;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("error at %0d ns: %s read %0h, expected %0h", $time, what, got, exp);
		errors++;
	endtask

	task automatic print_test_result(input string name);
		tests_run++;
		if (errors == test_errors)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic register_readback();
		logic [7:0] addrs [4];
		logic [7:0] val;
		logic [7:0] got;
		addrs[0] = REG_SCY;
		addrs[1] = REG_SCX;
		addrs[2] = REG_LYC;
		addrs[3] = REG_BGP;
		for (int round = 0; round < 8; round++) begin
			for (int i = 0; i < 4; i++) begin
				val = rand_bits(8);
				cpu_write(1'b0, addrs[i], val);
				cpu_read(1'b0, addrs[i], got);
				checks++;
				if (got !== val)
					report_mismatch($sformatf("register %0h", addrs[i]), got, val);
			end
		end
		// unmapped offsets are moved out of the 40h..47h block
		for (int i = 0; i < 8; i++) begin
			val = rand_bits(8);
			if (val[7:3] == 5'b01000)
				val = val ^ 8'h80;
			cpu_read(1'b0, val, got);
			checks++;
			if (got !== 8'hff)
				report_mismatch($sformatf("unmapped %0h", val), got, 8'hff);
		end
		cpu_read(1'b0, REG_STAT, got);
		checks++;
		if (got[7] !== 1'b1)
			report_mismatch("stat bit 7", got[7], 1);
	endtask

	task automatic beam_and_mode();
		int         h;
		int         v;
		logic [1:0] exp_mode;
		cpu_write(1'b0, REG_LCDC, 8'h91);
		// cycle k counts from the first cycle with lcdc on
		for (int k = 0; k < FRAME_CYCLES; k++) begin
			@(negedge clk_reg);
			h = k % LINE_CYCLES;
			v = k / LINE_CYCLES;
			if (v >= VISIBLE_LINES)
				exp_mode = 2'd1;
			else if (h < OAM_CYCLES)
				exp_mode = 2'd2;
			else if (h < OAM_CYCLES + DRAW_CYCLES)
				exp_mode = 2'd3;
			else
				exp_mode = 2'd0;
			checks += 3;
			if (mode !== exp_mode)
				report_mismatch($sformatf("mode at line %0d cycle %0d", v, h), mode, exp_mode);
			if (cpu_do !== v[7:0])
				report_mismatch($sformatf("ly at line %0d cycle %0d", v, h), cpu_do, v);
			if (lcd_on !== 1'b1)
				report_mismatch("lcd_on with lcd on", lcd_on, 1);
		end
		cpu_write(1'b0, REG_LCDC, 8'h00);
		// counters clear on the edge after lcdc reads off
		@(negedge clk_reg);
		for (int k = 0; k < 2 * LINE_CYCLES; k++) begin
			@(negedge clk_reg);
			checks += 4;
			if (mode !== 2'd0)
				report_mismatch("mode with lcd off", mode, 0);
			if (cpu_do !== 8'h00)
				report_mismatch("ly with lcd off", cpu_do, 0);
			if (vram_rd !== 1'b0)
				report_mismatch("vram_rd with lcd off", vram_rd, 0);
			if (lcd_on !== 1'b0)
				report_mismatch("lcd_on with lcd off", lcd_on, 0);
		end
	endtask

	task automatic interrupt_counts();
		logic [7:0] lyc;
		int         pulses;
		int         exp_pulses;
		// sources lyc, oam, vblank and hblank in stat bit order 6 down to 3
		for (int src = 0; src < 4; src++) begin
			lyc = rand_bits(8);
			cpu_write(1'b0, REG_LCDC, 8'h00);
			cpu_write(1'b0, REG_LYC, lyc);
			cpu_write(1'b0, REG_STAT, 8'h40 >> src);
			cpu_write(1'b0, REG_LCDC, 8'h91);
			pulses = 0;
			for (int k = 0; k < FRAME_CYCLES; k++) begin
				@(negedge clk_reg);
				if (irq === 1'b1)
					pulses++;
			end
			case (src)
				0:       exp_pulses = (lyc < FRAME_LINES) ? 1 : 0;
				1:       exp_pulses = VISIBLE_LINES;
				2:       exp_pulses = 1;
				default: exp_pulses = VISIBLE_LINES;
			endcase
			checks++;
			if (pulses != exp_pulses)
				report_mismatch($sformatf("irq count for source %0d", src), pulses, exp_pulses);
		end
	endtask

	// one frame of lcd output with pixels counted per beam line
	task automatic collect_frame(input logic bg_on, input logic [7:0] scx, input logic [7:0] scy,
		input logic [7:0] bgp, input logic map_sel, input logic data_sel);
		int         line_pix [FRAME_LINES];
		int         full_lines;
		int         line;
		int         exp_cnt;
		logic [1:0] exp_shade;
		full_lines = 0;
		for (int i = 0; i < FRAME_LINES; i++)
			line_pix[i] = 0;
		for (int k = 0; k < FRAME_CYCLES; k++) begin
			@(negedge clk_reg);
			if (lcd_clkena === 1'b1) begin
				line = k / LINE_CYCLES;
				if (bg_on)
					exp_shade = palette_shade(bgp,
						bg_index(line, line_pix[line], scx, scy, map_sel, data_sel));
				else
					exp_shade = 2'd0;
				checks++;
				if (lcd_data !== exp_shade)
					report_mismatch($sformatf("shade line %0d pixel %0d", line, line_pix[line]),
						lcd_data, exp_shade);
				line_pix[line]++;
			end
		end
		for (int i = 0; i < FRAME_LINES; i++) begin
			exp_cnt = (i < VISIBLE_LINES) ? SCREEN_WIDTH : 0;
			checks++;
			if (line_pix[i] != exp_cnt)
				report_mismatch($sformatf("pixel count on line %0d", i), line_pix[i], exp_cnt);
			if (line_pix[i] == SCREEN_WIDTH)
				full_lines++;
		end
		checks++;
		if (full_lines != VISIBLE_LINES)
			report_mismatch("lines in frame", full_lines, VISIBLE_LINES);
	endtask

	task automatic frame_pixels(input logic bg_on);
		logic [7:0] scx;
		logic [7:0] scy;
		logic [7:0] bgp;
		logic       map_sel;
		logic       data_sel;
		scx = rand_bits(8);
		scy = rand_bits(8);
		bgp = rand_bits(8);
		map_sel = rand_bits(1);
		data_sel = rand_bits(1);
		cpu_write(1'b0, REG_LCDC, 8'h00);
		cpu_write(1'b0, REG_SCX, scx);
		cpu_write(1'b0, REG_SCY, scy);
		cpu_write(1'b0, REG_BGP, bgp);
		cpu_write(1'b0, REG_LCDC, {1'b1, 2'b00, data_sel, map_sel, 2'b00, bg_on});
		collect_frame(bg_on, scx, scy, bgp, map_sel, data_sel);
	endtask

	task automatic oam_dma();
		logic [7:0] page;
		logic [7:0] got;
		logic [7:0] idx;
		int         dma_len;
		page = rand_bits(8);
		cpu_write(1'b0, REG_DMA, page);
		fork
			begin
				dma_len = 0;
				@(negedge clk_reg);
				while (dma_rd === 1'b1 && dma_len < 2 * DMA_BYTES * DMA_SLOT) begin
					idx = dma_len / DMA_SLOT;
					checks++;
					if (dma_addr !== {page, idx})
						report_mismatch("dma address", dma_addr, {page, idx});
					dma_len++;
					@(negedge clk_reg);
				end
			end
			// byte 0 is already copied and this write must be dropped
			begin
				repeat (200) @(posedge clk_reg);
				cpu_write(1'b1, 8'd0, ~dma_byte({page, 8'd0}));
			end
		join
		checks++;
		if (dma_len != DMA_BYTES * DMA_SLOT)
			report_mismatch("dma_rd high cycles", dma_len, DMA_BYTES * DMA_SLOT);
		for (int i = 0; i < DMA_BYTES; i++) begin
			cpu_read(1'b1, i, got);
			checks++;
			if (got !== dma_byte({page, 8'(i)}))
				report_mismatch($sformatf("oam byte %0d", i), got, dma_byte({page, 8'(i)}));
		end
		cpu_read(1'b1, 8'd160, got);
		checks++;
		if (got !== 8'hff)
			report_mismatch("oam above 160", got, 8'hff);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		lfsr_state = 16'd97;
		reset = 1'b1;
		cpu = {1'b0, 1'b1, REG_LY, 1'b0, 8'h00};
		vram_data = 8'h00;
		dma_data = 8'h00;
		checks = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		// vram image with one lfsr byte per address
		for (int a = 0; a < 8192; a++)
			vram_mem[a] = rand_bits(8);
		repeat (2) @(posedge clk_reg);
		reset <= 1'b0;
		@(negedge clk_reg);
		checks += 3;
		if (dma_rd !== 1'b0)
			report_mismatch("dma_rd after reset", dma_rd, 0);
		if (irq !== 1'b0)
			report_mismatch("irq after reset", irq, 0);
		if (lcd_clkena !== 1'b0)
			report_mismatch("lcd_clkena after reset", lcd_clkena, 0);
		print_test_result("reset state");
		register_readback();
		print_test_result("register readback");
		beam_and_mode();
		print_test_result("beam and mode");
		interrupt_counts();
		print_test_result("interrupt counts");
		frame_pixels(1'b1);
		print_test_result("background pixels");
		frame_pixels(1'b0);
		print_test_result("background off");
		oam_dma();
		print_test_result("oam dma");
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
video_pkg.sv
video_reg_decode.sv
video_beam_timing.sv
video_bg_fetch.sv
video_shade_out.sv
video_oam_dma.sv
video_top.sv
tb_video.sv
